// ==== source/rp_cfg.svh ====
`ifndef RP_CFG_SVH
`define RP_CFG_SVH

// bus and sample widths
`define RP_BUS_W        32
`define RP_SMP_W        14
`define RP_ADC_PIN_W    16              // two low pins reserved

// region map, selected by addr[22:20]
`define RP_REGIONS      8
`define RP_REGION_HK    3'd0
`define RP_REGION_MIX   3'd3

// housekeeping
`define RP_HK_ID        32'h5250_0001
`define RP_HK_ID_OFS    20'h00000
`define RP_HK_LOOP_OFS  20'h00004
`define RP_HK_LED_OFS   20'h00030

// output mixer
`define RP_MIX_CTRL_OFS     20'h00000
`define RP_MIX_CONST_A_OFS  20'h00004
`define RP_MIX_CONST_B_OFS  20'h00008
`define RP_MIX_OFFS_A_OFS   20'h0000C
`define RP_MIX_OFFS_B_OFS   20'h00010
`define RP_MIX_CTRL_RST     4'b0100     // a <- adc a, b <- adc b
`define RP_DAC_IDLE         14'h1FFF    // signed zero in dac code

`endif

// ==== source/rp_pkg.sv ====
`include "rp_cfg.svh"

package rp_pkg;

  //////////////////////////////////////////////////
  // system bus address, raw word or split fields
  //////////////////////////////////////////////////

  typedef union packed {
    logic [`RP_BUS_W-1:0] word;                   // as driven by the master
    struct packed {
      logic [8:0]                     spare;      // above region, ignored
      logic [$clog2(`RP_REGIONS)-1:0] region;     // bits 22..20
      logic [19:0]                    offset;     // slave register offset
    } fld;
  } sys_addr_u;

  // decoder looks at fld.region only,
  // slaves look at fld.offset only

endpackage

// ==== source/sys_bus_if.sv ====
`timescale 1ns/1ps
`include "rp_cfg.svh"

// one decoder-to-slave port of the system bus
interface sys_bus_if import rp_pkg::*; ();

  sys_addr_u            addr;   // full address, forwarded to every slave
  logic [`RP_BUS_W-1:0] wdata;  // full-word writes only
  logic                 wen;    // one-cycle pulse, this slave only
  logic                 ren;    // one-cycle pulse, this slave only
  logic [`RP_BUS_W-1:0] rdata;  // valid while ack is high
  logic                 ack;    // one cycle after wen/ren

  // decoder side
  modport master (
    output addr, wdata, wen, ren,
    input  rdata, ack
  );

  // register block side
  modport slave (
    input  addr, wdata, wen, ren,
    output rdata, ack
  );

endinterface

// ==== source/sys_bus_decoder.sv ====
`timescale 1ns/1ps
`include "rp_cfg.svh"

module sys_bus_decoder import rp_pkg::*; (
  // plain bus from the top
  input  logic [`RP_BUS_W-1:0] sys_addr_i,
  input  logic [`RP_BUS_W-1:0] sys_wdata_i,
  input  logic                 sys_wen_i,
  input  logic                 sys_ren_i,
  output logic [`RP_BUS_W-1:0] sys_rdata_o,
  output logic                 sys_ack_o,
  // slave ports
  sys_bus_if.master            hk_bus,   // region 0
  sys_bus_if.master            mix_bus   // region 3
);

  sys_addr_u addr_u;
  logic      hk_sel;
  logic      mix_sel;
  logic      unused_sel;
  logic      strobe;

  //////////////////////////////////////////////////
  // region decode
  //////////////////////////////////////////////////

  assign addr_u.word = sys_addr_i;
  assign hk_sel      = (addr_u.fld.region == `RP_REGION_HK);
  assign mix_sel     = (addr_u.fld.region == `RP_REGION_MIX);
  assign unused_sel  = ~(hk_sel | mix_sel);      // six empty regions
  assign strobe      = sys_wen_i | sys_ren_i;

  //////////////////////////////////////////////////
  // strobe steering
  //////////////////////////////////////////////////

  // address and data go everywhere
  assign hk_bus.addr   = addr_u;
  assign hk_bus.wdata  = sys_wdata_i;
  assign mix_bus.addr  = addr_u;
  assign mix_bus.wdata = sys_wdata_i;

  // strobes only to the addressed slave
  assign hk_bus.wen  = sys_wen_i & hk_sel;
  assign hk_bus.ren  = sys_ren_i & hk_sel;
  assign mix_bus.wen = sys_wen_i & mix_sel;
  assign mix_bus.ren = sys_ren_i & mix_sel;

  //////////////////////////////////////////////////
  // read data and ack return
  //////////////////////////////////////////////////

  // slave acks come the cycle after their strobe, so pick the slave
  // that is acking rather than the region on the bus right now
  always_comb
  begin
    if (hk_bus.ack)
      sys_rdata_o = hk_bus.rdata;
    else if (mix_bus.ack)
      sys_rdata_o = mix_bus.rdata;
    else
      sys_rdata_o = '0;                          // empty region reads zero
  end

  // empty regions ack in the strobe cycle itself
  assign sys_ack_o = hk_bus.ack | mix_bus.ack | (strobe & unused_sel);

endmodule

// ==== source/housekeeping.sv ====
`timescale 1ns/1ps
`include "rp_cfg.svh"

module housekeeping import rp_pkg::*; (
  input  logic       adc_clk,
  input  logic       rst_i,
  sys_bus_if.slave   bus,
  output logic       digital_loop_o,  // adc side takes mixer output
  output logic [7:0] led_o
);

  sys_addr_u            addr_q;   // address of the pending access
  logic [`RP_BUS_W-1:0] wdata_q;
  logic                 wen_q;
  logic                 ren_q;

  //////////////////////////////////////////////////
  // bus access stage, one cycle
  //////////////////////////////////////////////////

  always_ff @(posedge adc_clk)
  begin
    if (rst_i)
    begin
      wen_q <= 1'b0;
      ren_q <= 1'b0;
    end
    else
    begin
      wen_q <= bus.wen;
      ren_q <= bus.ren;
    end
  end

  always_ff @(posedge adc_clk)
  begin
    if (bus.wen | bus.ren)
    begin
      addr_q  <= bus.addr;
      wdata_q <= bus.wdata;
    end
  end

  assign bus.ack = wen_q | ren_q;

  //////////////////////////////////////////////////
  // register file
  //////////////////////////////////////////////////

  // write lands at the end of the ack cycle
  always_ff @(posedge adc_clk)
  begin
    if (rst_i)
    begin
      digital_loop_o <= 1'b0;
      led_o          <= '0;
    end
    else if (wen_q)
    begin
      case (addr_q.fld.offset)
        `RP_HK_LOOP_OFS: digital_loop_o <= wdata_q[0];
        `RP_HK_LED_OFS:  led_o          <= wdata_q[7:0];
        default:         ;                         // id is read only
      endcase
    end
  end

  always_comb
  begin
    case (addr_q.fld.offset)
      `RP_HK_ID_OFS:   bus.rdata = `RP_HK_ID;
      `RP_HK_LOOP_OFS: bus.rdata = {{(`RP_BUS_W-1){1'b0}}, digital_loop_o};
      `RP_HK_LED_OFS:  bus.rdata = {{(`RP_BUS_W-8){1'b0}}, led_o};
      default:         bus.rdata = '0;
    endcase
  end

endmodule

// ==== source/analog_io.sv ====
`timescale 1ns/1ps
`include "rp_cfg.svh"

module analog_io (
  input  logic                        adc_clk,
  input  logic                        rst_i,
  // adc pins, negative slope offset code
  input  logic [`RP_ADC_PIN_W-1:0]    adc_dat_a_i,
  input  logic [`RP_ADC_PIN_W-1:0]    adc_dat_b_i,
  input  logic                        digital_loop_i,
  // mixer side, two's complement
  input  logic signed [`RP_SMP_W-1:0] mix_a_i,
  input  logic signed [`RP_SMP_W-1:0] mix_b_i,
  output logic signed [`RP_SMP_W-1:0] adc_a_o,
  output logic signed [`RP_SMP_W-1:0] adc_b_o,
  // dac pins
  output logic [`RP_SMP_W-1:0]        dac_dat_a_o,
  output logic [`RP_SMP_W-1:0]        dac_dat_b_o
);

  logic [`RP_SMP_W-1:0] adc_dat_a;   // pin register
  logic [`RP_SMP_W-1:0] adc_dat_b;

  // keep sign, flip the rest
  // same mapping in both directions
  function automatic logic [`RP_SMP_W-1:0] neg_slope(input logic [`RP_SMP_W-1:0] v);
    neg_slope = {v[`RP_SMP_W-1], ~v[`RP_SMP_W-2:0]};
  endfunction

  //////////////////////////////////////////////////
  // adc side
  //////////////////////////////////////////////////

  // io register, lowest two pin bits dropped
  always_ff @(posedge adc_clk)
  begin
    adc_dat_a <= adc_dat_a_i[`RP_ADC_PIN_W-1 -: `RP_SMP_W];
    adc_dat_b <= adc_dat_b_i[`RP_ADC_PIN_W-1 -: `RP_SMP_W];
  end

  // loopback closes through the mixer register only
  assign adc_a_o = digital_loop_i ? mix_a_i : $signed(neg_slope(adc_dat_a));
  assign adc_b_o = digital_loop_i ? mix_b_i : $signed(neg_slope(adc_dat_b));

  //////////////////////////////////////////////////
  // dac side
  //////////////////////////////////////////////////

  always_ff @(posedge adc_clk)
  begin
    if (rst_i)
    begin
      dac_dat_a_o <= `RP_DAC_IDLE;               // mid scale
      dac_dat_b_o <= `RP_DAC_IDLE;
    end
    else
    begin
      dac_dat_a_o <= neg_slope(mix_a_i);
      dac_dat_b_o <= neg_slope(mix_b_i);
    end
  end

endmodule

// ==== source/output_mixer.sv ====
`timescale 1ns/1ps
`include "rp_cfg.svh"

module output_mixer import rp_pkg::*; (
  input  logic                        adc_clk,
  input  logic                        rst_i,
  sys_bus_if.slave                    bus,
  input  logic signed [`RP_SMP_W-1:0] adc_a_i,
  input  logic signed [`RP_SMP_W-1:0] adc_b_i,
  output logic signed [`RP_SMP_W-1:0] mix_a_o,
  output logic signed [`RP_SMP_W-1:0] mix_b_o
);

  // source select codes, per channel
  localparam logic [1:0] SRC_ADC_A = 2'd0;
  localparam logic [1:0] SRC_ADC_B = 2'd1;
  localparam logic [1:0] SRC_CONST = 2'd2;
  localparam logic [1:0] SRC_ZERO  = 2'd3;

  sys_addr_u                   addr_q;
  logic [`RP_BUS_W-1:0]        wdata_q;
  logic                        wen_q;
  logic                        ren_q;
  logic [3:0]                  ctrl;      // [1:0] chan a, [3:2] chan b
  logic signed [`RP_SMP_W-1:0] const_a;
  logic signed [`RP_SMP_W-1:0] const_b;
  logic signed [`RP_SMP_W-1:0] offs_a;
  logic signed [`RP_SMP_W-1:0] offs_b;

  // select, add offset, clamp to 14 bit signed
  function automatic logic signed [`RP_SMP_W-1:0] mix_chan(
    input logic [1:0]                  sel,
    input logic signed [`RP_SMP_W-1:0] a,
    input logic signed [`RP_SMP_W-1:0] b,
    input logic signed [`RP_SMP_W-1:0] cst,
    input logic signed [`RP_SMP_W-1:0] ofs
  );
    logic signed [`RP_SMP_W-1:0] src;
    logic signed [`RP_SMP_W:0]   sum;    // one guard bit
    case (sel)
      SRC_ADC_A: src = a;
      SRC_ADC_B: src = b;
      SRC_CONST: src = cst;
      SRC_ZERO:  src = '0;
    endcase
    sum = src + ofs;
    if (sum[`RP_SMP_W] != sum[`RP_SMP_W-1])      // overflow
      mix_chan = sum[`RP_SMP_W] ? {1'b1, {(`RP_SMP_W-1){1'b0}}}
                                : {1'b0, {(`RP_SMP_W-1){1'b1}}};
    else
      mix_chan = sum[`RP_SMP_W-1:0];
  endfunction

  //////////////////////////////////////////////////
  // bus access stage
  //////////////////////////////////////////////////

  always_ff @(posedge adc_clk)
  begin
    if (rst_i)
    begin
      wen_q <= 1'b0;
      ren_q <= 1'b0;
    end
    else
    begin
      wen_q <= bus.wen;
      ren_q <= bus.ren;
    end
  end

  always_ff @(posedge adc_clk)
  begin
    if (bus.wen | bus.ren)
    begin
      addr_q  <= bus.addr;
      wdata_q <= bus.wdata;
    end
  end

  assign bus.ack = wen_q | ren_q;

  //////////////////////////////////////////////////
  // registers
  //////////////////////////////////////////////////

  always_ff @(posedge adc_clk)
  begin
    if (rst_i)
    begin
      ctrl    <= `RP_MIX_CTRL_RST;
      const_a <= '0;
      const_b <= '0;
      offs_a  <= '0;
      offs_b  <= '0;
    end
    else if (wen_q)
    begin
      case (addr_q.fld.offset)
        `RP_MIX_CTRL_OFS:    ctrl    <= wdata_q[3:0];
        `RP_MIX_CONST_A_OFS: const_a <= wdata_q[`RP_SMP_W-1:0];
        `RP_MIX_CONST_B_OFS: const_b <= wdata_q[`RP_SMP_W-1:0];
        `RP_MIX_OFFS_A_OFS:  offs_a  <= wdata_q[`RP_SMP_W-1:0];
        `RP_MIX_OFFS_B_OFS:  offs_b  <= wdata_q[`RP_SMP_W-1:0];
        default:             ;
      endcase
    end
  end

  always_comb
  begin
    case (addr_q.fld.offset)
      `RP_MIX_CTRL_OFS:    bus.rdata = {{(`RP_BUS_W-4){1'b0}}, ctrl};
      `RP_MIX_CONST_A_OFS: bus.rdata = {{(`RP_BUS_W-`RP_SMP_W){1'b0}}, const_a};
      `RP_MIX_CONST_B_OFS: bus.rdata = {{(`RP_BUS_W-`RP_SMP_W){1'b0}}, const_b};
      `RP_MIX_OFFS_A_OFS:  bus.rdata = {{(`RP_BUS_W-`RP_SMP_W){1'b0}}, offs_a};
      `RP_MIX_OFFS_B_OFS:  bus.rdata = {{(`RP_BUS_W-`RP_SMP_W){1'b0}}, offs_b};
      default:             bus.rdata = '0;
    endcase
  end

  // mixer output register
  always_ff @(posedge adc_clk)
  begin
    if (rst_i)
    begin
      mix_a_o <= '0;
      mix_b_o <= '0;
    end
    else
    begin
      mix_a_o <= mix_chan(ctrl[1:0], adc_a_i, adc_b_i, const_a, offs_a);
      mix_b_o <= mix_chan(ctrl[3:2], adc_a_i, adc_b_i, const_b, offs_b);
    end
  end

endmodule

// ==== source/rp_top.sv ====
`timescale 1ns/1ps
`include "rp_cfg.svh"

module rp_top (
  input  logic                     adc_clk,
  input  logic                     rst_i,
  // adc / dac
  input  logic [`RP_ADC_PIN_W-1:0] adc_dat_a_i,
  input  logic [`RP_ADC_PIN_W-1:0] adc_dat_b_i,
  output logic [`RP_SMP_W-1:0]     dac_dat_a_o,
  output logic [`RP_SMP_W-1:0]     dac_dat_b_o,
  output logic [7:0]               led_o,
  // system bus
  input  logic [`RP_BUS_W-1:0]     sys_addr_i,
  input  logic [`RP_BUS_W-1:0]     sys_wdata_i,
  input  logic                     sys_wen_i,
  input  logic                     sys_ren_i,
  output logic [`RP_BUS_W-1:0]     sys_rdata_o,
  output logic                     sys_ack_o
);

  logic signed [`RP_SMP_W-1:0] adc_a;   // two's complement, after loop mux
  logic signed [`RP_SMP_W-1:0] adc_b;
  logic signed [`RP_SMP_W-1:0] mix_a;   // mixer register out
  logic signed [`RP_SMP_W-1:0] mix_b;
  logic                        digital_loop;

  sys_bus_if hk_bus ();
  sys_bus_if mix_bus ();

  //////////////////////////////////////////////////
  // bus decoder, 8 regions on addr[22:20]
  //////////////////////////////////////////////////

  sys_bus_decoder sys_bus_decoder_i (
    .sys_addr_i  (sys_addr_i),
    .sys_wdata_i (sys_wdata_i),
    .sys_wen_i   (sys_wen_i),
    .sys_ren_i   (sys_ren_i),
    .sys_rdata_o (sys_rdata_o),
    .sys_ack_o   (sys_ack_o),
    .hk_bus      (hk_bus),
    .mix_bus     (mix_bus)
  );

  housekeeping housekeeping_i (
    .adc_clk        (adc_clk),
    .rst_i          (rst_i),
    .bus            (hk_bus),
    .digital_loop_o (digital_loop),
    .led_o          (led_o)
  );

  //////////////////////////////////////////////////
  // fast analog path
  //////////////////////////////////////////////////

  analog_io analog_io_i (
    .adc_clk        (adc_clk),
    .rst_i          (rst_i),
    .adc_dat_a_i    (adc_dat_a_i),
    .adc_dat_b_i    (adc_dat_b_i),
    .digital_loop_i (digital_loop),
    .mix_a_i        (mix_a),
    .mix_b_i        (mix_b),
    .adc_a_o        (adc_a),
    .adc_b_o        (adc_b),
    .dac_dat_a_o    (dac_dat_a_o),
    .dac_dat_b_o    (dac_dat_b_o)
  );

  output_mixer output_mixer_i (
    .adc_clk (adc_clk),
    .rst_i   (rst_i),
    .bus     (mix_bus),
    .adc_a_i (adc_a),
    .adc_b_i (adc_b),
    .mix_a_o (mix_a),
    .mix_b_o (mix_b)
  );

endmodule

// ==== verification/rp_top_asserts.sv ====
`timescale 1ns/1ps
`include "rp_cfg.svh"

module rp_top_asserts (
  input logic                 adc_clk,
  input logic                 rst_i,
  input logic [`RP_BUS_W-1:0] sys_addr_i,
  input logic                 sys_wen_i,
  input logic                 sys_ren_i,
  input logic [`RP_BUS_W-1:0] sys_rdata_i,   // dut sys_rdata_o
  input logic                 sys_ack_i      // dut sys_ack_o
);

  logic [2:0] region;
  logic       strobe;
  logic       slave_sel;        // region 0 or 3
  logic       slave_strobe_q;   // slave strobe one cycle ago

  assign region    = sys_addr_i[22:20];
  assign strobe    = sys_wen_i | sys_ren_i;
  assign slave_sel = (region == `RP_REGION_HK) || (region == `RP_REGION_MIX);

  always_ff @(posedge adc_clk)
  begin
    if (rst_i)
      slave_strobe_q <= 1'b0;
    else
      slave_strobe_q <= strobe & slave_sel;
  end

  //////////////////////////////////////////////////
  // bus protocol
  //////////////////////////////////////////////////

  strobe_excl: assert property (@(posedge adc_clk) disable iff (rst_i)
    !(sys_wen_i && sys_ren_i))
    else $error("wen and ren high in the same cycle");

  ack_cause: assert property (@(posedge adc_clk) disable iff (rst_i)
    sys_ack_i |-> (strobe || slave_strobe_q))   // same cycle or one late
    else $error("ack without a strobe to answer");

  empty_rdata: assert property (@(posedge adc_clk) disable iff (rst_i)
    (sys_ack_i && strobe && !slave_sel && !slave_strobe_q) |-> (sys_rdata_i == '0))
    else $error("empty region answered with nonzero data");

endmodule

bind rp_top rp_top_asserts rp_top_asserts_i (
  .adc_clk     (adc_clk),
  .rst_i       (rst_i),
  .sys_addr_i  (sys_addr_i),
  .sys_wen_i   (sys_wen_i),
  .sys_ren_i   (sys_ren_i),
  .sys_rdata_i (sys_rdata_o),
  .sys_ack_i   (sys_ack_o)
);

// ==== verification/rp_top_tb.sv ====
`timescale 1ns/1ps
`include "rp_cfg.svh"

module rp_top_tb;

  localparam int ACC_CYC     = 3;      // strobe, ack, gap
  localparam int STIM_CYCLES = 16 + 21*ACC_CYC + 4*(2*ACC_CYC + 200) + 6*(10*ACC_CYC + 60)
                             + 2*ACC_CYC + 4*(3*ACC_CYC + 80) + 20*(2*ACC_CYC + 1);
  localparam int MAX_CYCLES  = STIM_CYCLES * 3 / 2;   // about 3000
  localparam int SMP_MAX     = (1 << (`RP_SMP_W-1)) - 1;
  localparam int SMP_MIN     = -(1 << (`RP_SMP_W-1));

  logic                     adc_clk;
  logic                     rst_i;
  logic [`RP_ADC_PIN_W-1:0] adc_dat_a_i;
  logic [`RP_ADC_PIN_W-1:0] adc_dat_b_i;
  logic [`RP_SMP_W-1:0]     dac_dat_a_o;
  logic [`RP_SMP_W-1:0]     dac_dat_b_o;
  logic [7:0]               led_o;
  logic [`RP_BUS_W-1:0]     sys_addr_i;
  logic [`RP_BUS_W-1:0]     sys_wdata_i;
  logic                     sys_wen_i;
  logic                     sys_ren_i;
  logic [`RP_BUS_W-1:0]     sys_rdata_o;
  logic                     sys_ack_o;

  integer seed;
  int     errors;
  int     checks;
  int     cycles;
  logic   check_en;

  // model state as of the last rising edge
  int                   m_adc_a, m_adc_b;     // signed after conversion
  int                   m_mix_a, m_mix_b;
  logic [`RP_SMP_W-1:0] m_dac_a, m_dac_b;
  logic [3:0]           m_ctrl;
  logic [`RP_SMP_W-1:0] m_const_a, m_const_b, m_offs_a, m_offs_b;
  logic                 m_loop;
  logic [7:0]           m_led;
  logic                 m_pwen, m_pren;       // access waiting for its ack
  logic [2:0]           m_preg;
  logic [19:0]          m_pofs;
  logic [31:0]          m_pdat;

  rp_top rp_top_i (.*);

  initial
  begin
    adc_clk = 1'b0;
    forever #20 adc_clk = ~adc_clk;         // 25 MHz
  end

  //////////////////////////////////////////////////
  // reference model
  //////////////////////////////////////////////////

  // sign kept and 13 lower bits inverted
  // its own inverse
  function automatic logic [`RP_SMP_W-1:0] flip_code(input logic [`RP_SMP_W-1:0] v);
    flip_code = v ^ 14'h1FFF;
  endfunction

  function automatic int to_int(input logic [`RP_SMP_W-1:0] v);
    to_int = v[`RP_SMP_W-1] ? int'(v) - (1 << `RP_SMP_W) : int'(v);
  endfunction

  function automatic int mix_model(input logic [1:0] sel, input int a, input int b,
                                   input logic [`RP_SMP_W-1:0] cst,
                                   input logic [`RP_SMP_W-1:0] ofs);
    int sum;
    case (sel)
      2'd0:    sum = a;
      2'd1:    sum = b;
      2'd2:    sum = to_int(cst);
      default: sum = 0;
    endcase
    sum = sum + to_int(ofs);
    if (sum > SMP_MAX)
      sum = SMP_MAX;                        // clamp at 1fff
    if (sum < SMP_MIN)
      sum = SMP_MIN;                        // clamp at 2000
    mix_model = sum;
  endfunction

  function automatic logic [31:0] reg_model(input logic [2:0] region, input logic [19:0] ofs);
    reg_model = '0;
    if (region == `RP_REGION_HK)
      case (ofs)
        `RP_HK_ID_OFS:   reg_model = `RP_HK_ID;
        `RP_HK_LOOP_OFS: reg_model = {31'h0, m_loop};
        `RP_HK_LED_OFS:  reg_model = {24'h0, m_led};
        default:         ;
      endcase
    else if (region == `RP_REGION_MIX)
      case (ofs)
        `RP_MIX_CTRL_OFS:    reg_model = {28'h0, m_ctrl};
        `RP_MIX_CONST_A_OFS: reg_model = {18'h0, m_const_a};
        `RP_MIX_CONST_B_OFS: reg_model = {18'h0, m_const_b};
        `RP_MIX_OFFS_A_OFS:  reg_model = {18'h0, m_offs_a};
        `RP_MIX_OFFS_B_OFS:  reg_model = {18'h0, m_offs_b};
        default:             ;
      endcase
  endfunction

  task automatic reg_write(input logic [2:0] region, input logic [19:0] ofs, input logic [31:0] d);
    if (region == `RP_REGION_HK)
      case (ofs)
        `RP_HK_LOOP_OFS: m_loop = d[0];
        `RP_HK_LED_OFS:  m_led  = d[7:0];
        default:         ;                  // id and holes ignore writes
      endcase
    else
      case (ofs)
        `RP_MIX_CTRL_OFS:    m_ctrl    = d[3:0];
        `RP_MIX_CONST_A_OFS: m_const_a = d[`RP_SMP_W-1:0];
        `RP_MIX_CONST_B_OFS: m_const_b = d[`RP_SMP_W-1:0];
        `RP_MIX_OFFS_A_OFS:  m_offs_a  = d[`RP_SMP_W-1:0];
        `RP_MIX_OFFS_B_OFS:  m_offs_b  = d[`RP_SMP_W-1:0];
        default:             ;
      endcase
  endtask

  task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    assert (got === exp)
    else
    begin
      $display("[FAIL] %s got %h expected %h at %0t", name, got, exp, $time);
      errors++;
    end
  endtask

  // compare at the falling edge and step the model over the next rising edge
  always @(negedge adc_clk)
  begin : model_step
    logic [2:0] region;
    logic       unused;
    logic       exp_ack;
    int         nxt_a;
    int         nxt_b;
    region  = sys_addr_i[22:20];
    unused  = (region != `RP_REGION_HK) && (region != `RP_REGION_MIX);
    exp_ack = m_pwen | m_pren | ((sys_wen_i | sys_ren_i) & unused);
    if (check_en)
    begin
      check_val("dac_dat_a_o", dac_dat_a_o, m_dac_a);
      check_val("dac_dat_b_o", dac_dat_b_o, m_dac_b);
      check_val("led_o", led_o, m_led);
      check_val("sys_ack_o", sys_ack_o, exp_ack);
      if (m_pren)
        check_val("sys_rdata_o", sys_rdata_o, reg_model(m_preg, m_pofs));
      else if (exp_ack && !m_pwen)
        check_val("sys_rdata_o", sys_rdata_o, 32'h0);   // empty region
    end
    if (rst_i)
    begin
      m_pwen    = 1'b0;
      m_pren    = 1'b0;
      m_ctrl    = `RP_MIX_CTRL_RST;
      m_const_a = '0;
      m_const_b = '0;
      m_offs_a  = '0;
      m_offs_b  = '0;
      m_loop    = 1'b0;
      m_led     = '0;
      m_mix_a   = 0;
      m_mix_b   = 0;
      m_dac_a   = `RP_DAC_IDLE;
      m_dac_b   = `RP_DAC_IDLE;
    end
    else
    begin
      // loopback feeds last mixer value back in
      nxt_a = mix_model(m_ctrl[1:0], m_loop ? m_mix_a : m_adc_a, m_loop ? m_mix_b : m_adc_b,
                        m_const_a, m_offs_a);
      nxt_b = mix_model(m_ctrl[3:2], m_loop ? m_mix_a : m_adc_a, m_loop ? m_mix_b : m_adc_b,
                        m_const_b, m_offs_b);
      m_dac_a = flip_code(m_mix_a[`RP_SMP_W-1:0]);
      m_dac_b = flip_code(m_mix_b[`RP_SMP_W-1:0]);
      m_mix_a = nxt_a;
      m_mix_b = nxt_b;
      if (m_pwen)
        reg_write(m_preg, m_pofs, m_pdat);    // lands at end of ack cycle
      m_pwen = sys_wen_i & ~unused;
      m_pren = sys_ren_i & ~unused;
      m_preg = region;
      m_pofs = sys_addr_i[19:0];
      m_pdat = sys_wdata_i;
    end
    m_adc_a = to_int(flip_code(adc_dat_a_i[`RP_ADC_PIN_W-1:2]));   // low pins dropped
    m_adc_b = to_int(flip_code(adc_dat_b_i[`RP_ADC_PIN_W-1:2]));
  end

  //////////////////////////////////////////////////
  // stimulus helpers
  //////////////////////////////////////////////////

  function automatic logic [31:0] rand_word();
    rand_word = $random(seed);
  endfunction

  function automatic logic [15:0] rand_pin();
    case ($unsigned($random(seed)) % 6)
      0:       rand_pin = 16'h0000;         // most positive sample
      1:       rand_pin = 16'hFFFF;         // most negative sample
      default: rand_pin = $random(seed);
    endcase
  endfunction

  // one of 1, 2, 4, 5, 6, 7
  function automatic logic [2:0] unused_region();
    int r;
    r = $unsigned($random(seed)) % 6;
    unused_region = (r < 2) ? 3'(r + 1) : 3'(r + 2);
  endfunction

  task automatic drive_pins(input int n);
    repeat (n)
    begin
      @(posedge adc_clk);
      adc_dat_a_i <= rand_pin();
      adc_dat_b_i <= rand_pin();
    end
  endtask

  task automatic bus_access(input logic wr, input logic [2:0] region, input logic [19:0] ofs,
                            input logic [31:0] wdata, output logic [31:0] rdata);
    logic [31:0] spare;
    int          wait_cnt;
    int          exp_lat;
    spare    = rand_word();                 // bits above region are don't care
    exp_lat  = (region == `RP_REGION_HK || region == `RP_REGION_MIX) ? 1 : 0;
    wait_cnt = 0;
    @(posedge adc_clk);
    sys_addr_i  <= {spare[31:23], region, ofs};
    sys_wdata_i <= wdata;
    sys_wen_i   <= wr;
    sys_ren_i   <= ~wr;
    @(negedge adc_clk);
    while (!sys_ack_o && wait_cnt < 4)
    begin
      @(posedge adc_clk);
      sys_wen_i <= 1'b0;                    // strobe is a single pulse
      sys_ren_i <= 1'b0;
      wait_cnt++;
      @(negedge adc_clk);
    end
    rdata = sys_rdata_o;
    assert (sys_ack_o)
    else
    begin
      $display("no ack from region %0d after %0d cycles", region, wait_cnt);
      errors++;
    end
    check_val("sys_ack_o latency", wait_cnt, exp_lat);
    @(posedge adc_clk);
    sys_wen_i <= 1'b0;
    sys_ren_i <= 1'b0;
  endtask

  task automatic bus_write(input logic [2:0] region, input logic [19:0] ofs,
                           input logic [31:0] wdata);
    logic [31:0] unused_rd;
    bus_access(1'b1, region, ofs, wdata, unused_rd);
  endtask

  task automatic bus_read(input logic [2:0] region, input logic [19:0] ofs,
                          output logic [31:0] rdata);
    bus_access(1'b0, region, ofs, 32'h0, rdata);
  endtask

  task automatic write_check(input logic [19:0] ofs, input logic [31:0] mask);
    logic [31:0] wd;
    logic [31:0] rd;
    wd = rand_word();
    bus_write(`RP_REGION_MIX, ofs, wd);
    bus_read(`RP_REGION_MIX, ofs, rd);
    check_val("sys_rdata_o", rd, wd & mask);
  endtask

  //////////////////////////////////////////////////
  // test sequence
  //////////////////////////////////////////////////

  initial
  begin
    logic [31:0] rd;
    logic [31:0] wd;
    seed        = 33;
    errors      = 0;
    checks      = 0;
    cycles      = 0;
    check_en    = 1'b0;
    rst_i       = 1'b1;
    adc_dat_a_i = '0;
    adc_dat_b_i = '0;
    sys_addr_i  = '0;
    sys_wdata_i = '0;
    sys_wen_i   = 1'b0;
    sys_ren_i   = 1'b0;
    repeat (2) @(posedge adc_clk);
    rst_i    <= 1'b0;
    check_en  = 1'b1;                       // idle dac, led and ack from here on
    drive_pins(4);

    // id word and empty regions
    bus_read(`RP_REGION_HK, `RP_HK_ID_OFS, rd);
    check_val("sys_rdata_o", rd, `RP_HK_ID);
    repeat (20)
    begin
      wd = rand_word();
      bus_access(wd[31], unused_region(), wd[19:0], rand_word(), rd);
      check_val("sys_rdata_o", rd, 32'h0);
    end

    // default routing with random offsets and then both rails
    for (int r = 0; r < 4; r++)
    begin
      wd = (r == 2) ? 32'h1FFF : (r == 3) ? 32'h2000 : rand_word();
      bus_write(`RP_REGION_MIX, `RP_MIX_OFFS_A_OFS, wd);
      bus_write(`RP_REGION_MIX, `RP_MIX_OFFS_B_OFS, (r < 2) ? rand_word() : wd);
      drive_pins(200);
    end

    // source select and constants
    for (int r = 0; r < 6; r++)
    begin
      write_check(`RP_MIX_CTRL_OFS, 32'hF);
      write_check(`RP_MIX_CONST_A_OFS, 32'h3FFF);
      write_check(`RP_MIX_CONST_B_OFS, 32'h3FFF);
      write_check(`RP_MIX_OFFS_A_OFS, 32'h3FFF);
      write_check(`RP_MIX_OFFS_B_OFS, 32'h3FFF);
      drive_pins(60);
    end

    // loopback while the pins keep toggling
    bus_write(`RP_REGION_HK, `RP_HK_LOOP_OFS, 32'h1);
    bus_read(`RP_REGION_HK, `RP_HK_LOOP_OFS, rd);
    check_val("sys_rdata_o", rd, 32'h1);
    for (int r = 0; r < 4; r++)
    begin
      bus_write(`RP_REGION_MIX, `RP_MIX_CTRL_OFS, rand_word());
      bus_write(`RP_REGION_MIX, `RP_MIX_OFFS_A_OFS, $random(seed) % 64);
      bus_write(`RP_REGION_MIX, `RP_MIX_OFFS_B_OFS, $random(seed) % 64);
      drive_pins(80);
    end
    bus_write(`RP_REGION_HK, `RP_HK_LOOP_OFS, 32'h0);

    // leds
    repeat (20)
    begin
      wd = rand_word();
      bus_write(`RP_REGION_HK, `RP_HK_LED_OFS, wd);
      @(negedge adc_clk);
      check_val("led_o", led_o, wd[7:0]);
      bus_read(`RP_REGION_HK, `RP_HK_LED_OFS, rd);
      check_val("sys_rdata_o", rd, {24'h0, wd[7:0]});
    end
    drive_pins(4);

    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0)
      $display("test passed");
    else
      $display("test failed");
    $finish;
  end

  // hung run guard
  always @(posedge adc_clk)
  begin
    cycles = cycles + 1;
    if (cycles >= MAX_CYCLES)
    begin
      $display("timeout after %0d cycles, checks %0d, errors %0d", cycles, checks, errors);
      $display("test failed");
      $finish;
    end
  end

endmodule

// ==== sources.f ====
+incdir+source
source/rp_pkg.sv
source/sys_bus_if.sv
source/sys_bus_decoder.sv
source/housekeeping.sv
source/analog_io.sv
source/output_mixer.sv
source/rp_top.sv
verification/rp_top_asserts.sv
verification/rp_top_tb.sv

// ==== run.sh ====
#!/bin/sh
# build and run rp_top_tb with verilator, pass only if the log says so
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log
verilator --binary --timing --assert -Wno-fatal --top-module rp_top_tb -f sources.f \
  > build.log 2>&1 || { echo "build failed, see build.log"; exit 1; }
./obj_dir/Vrp_top_tb > sim.log 2>&1
grep -qx "test passed" sim.log && echo "simulation ok" || {
  echo "simulation failed, see sim.log"
  exit 1
}
